// ==== Bender.yml ====
package:
  name: link_user

sources:
  - verilog/stream_pkg.sv
  - verilog/regs_pkg.sv
  - verilog/seq_append.sv
  - verilog/seq_strip.sv
  - verilog/loop_fifo.sv
  - verilog/link_regs.sv
  - verilog/link_user_top.sv
  - target: test
    files:
      - bench/tb_link_user.sv

// ==== bench/tb_link_user.sv ====
module tb_link_user
   import stream_pkg::*;
   import regs_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_FRAMES  = 24;               // Frames per test phase
   localparam int MAX_BEATS = 4 * N_FRAMES * 9;

   logic                  usr_clk;
   logic                  S_AXI_ARESETN;
   stream_beat_t          s_axis_tx;
   stream_beat_t          m_axis_rx;
   stream_beat_t          link_tx;
   stream_beat_t          link_rx;
   logic                  s_axis_tx_ready;
   logic                  link_tx_ready;
   logic [REG_ADDR_W-1:0] S_AXI_AWADDR;
   logic [REG_ADDR_W-1:0] S_AXI_ARADDR;
   logic [REG_DATA_W-1:0] S_AXI_WDATA;
   logic [REG_DATA_W-1:0] S_AXI_RDATA;
   logic                  S_AXI_AWVALID;
   logic                  S_AXI_AWREADY;
   logic                  S_AXI_WVALID;
   logic                  S_AXI_WREADY;
   logic                  S_AXI_BVALID;
   logic                  S_AXI_BREADY;
   logic                  S_AXI_ARVALID;
   logic                  S_AXI_ARREADY;
   logic                  S_AXI_RVALID;
   logic                  S_AXI_RREADY;

   integer       seed = 22212;
   stream_beat_t exp_tx[$];    // Expected link_tx beats
   stream_beat_t exp_rx[$];    // Expected m_axis_rx beats
   logic [31:0]  seq_model;
   logic [63:0]  rx_frames;
   logic [63:0]  tx_frames;
   logic         strip_flag;
   logic         loop_mode;

   link_user_top #(.LOOP_DEPTH(16)) uut (.*);

   initial begin
      usr_clk = 1'b0;
      forever #5 usr_clk = ~usr_clk;
   end

   // Link side back-pressure, low about a quarter of the time
   initial begin
      link_tx_ready = 1'b1;
      forever begin
         @(posedge usr_clk);
         #1 link_tx_ready = ({$random(seed)} % 4) != 0;
      end
   end

   initial begin
      repeat (200 * MAX_BEATS + 2000) @(posedge usr_clk);
      stop_failed("Timeout, the test did not finish");
   end

   task automatic stop_failed(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else begin
         stop_failed($sformatf("ERR %0t %s expected %0h actual %0h", $time, name, exp, act));
      end
   endtask

   function automatic stream_beat_t make_beat(input logic l, input logic [31:0] d);
      stream_beat_t b;
      b.valid = 1'b1;
      b.last  = l;
      b.data  = d;
      return b;
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge usr_clk);
         #1;
      end
   endtask

   // Wait until both expected queues have drained
   task automatic drain();
      while (exp_tx.size() != 0 || exp_rx.size() != 0) @(posedge usr_clk);
      idle_cycles(4);
   endtask

   task automatic reg_write(input logic [3:0] idx, input logic [31:0] d);
      S_AXI_AWADDR  = {idx, 2'b00};
      S_AXI_WDATA   = d;
      S_AXI_AWVALID = 1'b1;
      S_AXI_WVALID  = 1'b1;
      @(negedge usr_clk);
      while (!S_AXI_AWREADY) @(negedge usr_clk);
      check_val("S_AXI_WREADY", 64'h1, S_AXI_WREADY);   // Pulses with AWREADY
      idle_cycles(1);
      S_AXI_AWVALID = 1'b0;
      S_AXI_WVALID  = 1'b0;
      @(negedge usr_clk);
      while (!S_AXI_BVALID) @(negedge usr_clk);
      idle_cycles(1);
   endtask

   task automatic reg_read(input logic [3:0] idx, output logic [31:0] d);
      S_AXI_ARADDR  = {idx, 2'b00};
      S_AXI_ARVALID = 1'b1;
      @(negedge usr_clk);
      while (!S_AXI_ARREADY) @(negedge usr_clk);
      idle_cycles(1);
      S_AXI_ARVALID = 1'b0;
      @(negedge usr_clk);
      while (!S_AXI_RVALID) @(negedge usr_clk);
      d = S_AXI_RDATA;
      idle_cycles(1);
   endtask

   task automatic check_counters();
      logic [31:0] lo;
      logic [31:0] hi;
      reg_read(ADDR_CNT_IN_L, lo);
      reg_read(ADDR_CNT_IN_H, hi);
      check_val("cnt_in", rx_frames, {hi, lo});
      reg_read(ADDR_CNT_OUT_L, lo);
      reg_read(ADDR_CNT_OUT_H, hi);
      check_val("cnt_out", tx_frames, {hi, lo});
   endtask

   task automatic send_tx_frame(input int n);
      logic taken;
      for (int i = 0; i < n; i++) begin
         s_axis_tx = make_beat(i == n - 1, $random(seed));
         taken = 1'b0;
         while (!taken) begin
            @(negedge usr_clk);
            taken = s_axis_tx_ready;
            idle_cycles(1);
         end
      end
      s_axis_tx.valid = 1'b0;
      idle_cycles({$random(seed)} % 3);
   endtask

   // n payload words, then the trailing word
   task automatic send_rx_frame(input int n);
      logic [31:0] w;
      for (int i = 0; i <= n; i++) begin
         w = $random(seed);
         if (loop_mode) begin
            while (exp_tx.size() >= 8) idle_cycles(1);   // Keep the FIFO far from full
            exp_tx.push_back(make_beat(i == n, w));
            if (i == n) tx_frames = tx_frames + 1;
         end
         if (!strip_flag) exp_rx.push_back(make_beat(i == n, w));
         else if (i < n) exp_rx.push_back(make_beat(i == n - 1, w));
         link_rx = make_beat(i == n, w);
         idle_cycles(1);
         link_rx.valid = 1'b0;
         idle_cycles({$random(seed)} % 3);
      end
      rx_frames = rx_frames + 1;
   endtask

   // Transmit model and link_tx checker, sampled mid-cycle
   always @(negedge usr_clk) begin : tx_mon
      stream_beat_t e;
      if (S_AXI_ARESETN) begin
         if (link_tx.valid && link_tx_ready) begin
            assert (exp_tx.size() > 0)
               else stop_failed("A beat appeared on link_tx that was not expected");
            e = exp_tx.pop_front();
            check_val("link_tx.data", e.data, link_tx.data);
            check_val("link_tx.last", e.last, link_tx.last);
         end
         if (s_axis_tx.valid && s_axis_tx_ready) begin
            exp_tx.push_back(make_beat(1'b0, s_axis_tx.data));
            if (s_axis_tx.last) begin
               exp_tx.push_back(make_beat(1'b1, seq_model));   // Sequence word ends the frame
               seq_model = seq_model + 1;
               tx_frames = tx_frames + 1;
            end
         end
         if (loop_mode) begin
            assert (!s_axis_tx_ready)
               else stop_failed("s_axis_tx_ready went high in loopback mode");
         end
      end
   end

   always @(negedge usr_clk) begin : rx_mon
      stream_beat_t e;
      if (S_AXI_ARESETN && m_axis_rx.valid) begin
         assert (exp_rx.size() > 0)
            else stop_failed("A beat appeared on m_axis_rx that was not expected");
         e = exp_rx.pop_front();
         check_val("m_axis_rx.data", e.data, m_axis_rx.data);
         check_val("m_axis_rx.last", e.last, m_axis_rx.last);
      end
   end

   initial begin : main
      logic [31:0] rd;
      s_axis_tx     = '0;
      link_rx       = '0;
      S_AXI_ARESETN = 1'b0;
      S_AXI_AWADDR  = '0;
      S_AXI_ARADDR  = '0;
      S_AXI_WDATA   = '0;
      S_AXI_AWVALID = 1'b0;
      S_AXI_WVALID  = 1'b0;
      S_AXI_ARVALID = 1'b0;
      S_AXI_BREADY  = 1'b1;
      S_AXI_RREADY  = 1'b1;
      seq_model     = '0;
      rx_frames     = '0;
      tx_frames     = '0;
      strip_flag    = 1'b1;
      loop_mode     = 1'b0;
      idle_cycles(5);
      S_AXI_ARESETN = 1'b1;
      idle_cycles(2);

      reg_read(ADDR_CTRL, rd);
      check_val("ctrl", 64'h2, rd);   // strip_en on, loopback off
      check_counters();

      for (int f = 0; f < N_FRAMES; f++) send_tx_frame(f == 0 ? 1 : 1 + {$random(seed)} % 8);
      drain();

      // Stripping on, first frame is one word plus trailer
      for (int f = 0; f < N_FRAMES; f++) send_rx_frame(f == 0 ? 1 : 1 + {$random(seed)} % 8);
      drain();

      reg_write(ADDR_CTRL, 32'h0);
      strip_flag = 1'b0;
      for (int f = 0; f < N_FRAMES; f++) send_rx_frame(1 + {$random(seed)} % 8);
      drain();

      reg_write(ADDR_CTRL, 32'h1);
      loop_mode = 1'b1;
      s_axis_tx = make_beat(1'b1, $random(seed));   // User side offers data, must stay blocked
      for (int f = 0; f < N_FRAMES; f++) send_rx_frame(1 + {$random(seed)} % 8);
      drain();
      s_axis_tx.valid = 1'b0;

      reg_read(ADDR_STAT, rd);
      check_val("stat", 64'h1, rd);   // FIFO empty, not full
      check_counters();
      $display("test passed");
      $finish;
   end

endmodule

// ==== sources.f ====
verilog/stream_pkg.sv
verilog/regs_pkg.sv
verilog/seq_append.sv
verilog/seq_strip.sv
verilog/loop_fifo.sv
verilog/link_regs.sv
verilog/link_user_top.sv
bench/tb_link_user.sv

// ==== verilog/link_regs.sv ====
module link_regs
   import stream_pkg::*;
   import regs_pkg::*;
(
   input  logic                  usr_clk,
   input  logic                  S_AXI_ARESETN,
   input  logic [REG_ADDR_W-1:0] S_AXI_AWADDR,
   input  logic                  S_AXI_AWVALID,
   output logic                  S_AXI_AWREADY,
   input  logic [REG_DATA_W-1:0] S_AXI_WDATA,
   input  logic                  S_AXI_WVALID,
   output logic                  S_AXI_WREADY,
   output logic                  S_AXI_BVALID,
   input  logic                  S_AXI_BREADY,
   input  logic [REG_ADDR_W-1:0] S_AXI_ARADDR,
   input  logic                  S_AXI_ARVALID,
   output logic                  S_AXI_ARREADY,
   output logic [REG_DATA_W-1:0] S_AXI_RDATA,
   output logic                  S_AXI_RVALID,
   input  logic                  S_AXI_RREADY,
   output link_ctrl_t            ctrl,
   input  stream_beat_t          rx_beat,
   input  stream_beat_t          tx_beat,
   input  logic                  tx_ready,
   input  logic                  fifo_full,
   input  logic                  fifo_empty
);

   logic [3:0]            wr_idx;   // Latched word index
   logic [3:0]            rd_idx;
   logic                  wr_en;
   logic [63:0]           cnt_in;
   logic [63:0]           cnt_out;
   logic [REG_DATA_W-1:0] rd_mux;

   // Address and data accepted together, one-cycle ready pulse
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_AWREADY <= 1'b0;
         S_AXI_WREADY  <= 1'b0;
         wr_idx        <= '0;
      end else begin
         S_AXI_AWREADY <= !S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID;
         S_AXI_WREADY  <= !S_AXI_WREADY && S_AXI_AWVALID && S_AXI_WVALID;
         if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID) begin
            wr_idx <= S_AXI_AWADDR[REG_ADDR_W-1:2];
         end
      end
   end

   assign wr_en = S_AXI_AWREADY && S_AXI_WREADY && S_AXI_AWVALID && S_AXI_WVALID;

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_BVALID <= 1'b0;
      end else if (wr_en) begin
         S_AXI_BVALID <= 1'b1;
      end else if (S_AXI_BREADY) begin
         S_AXI_BVALID <= 1'b0;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         ctrl <= CTRL_RESET;
      end else if (wr_en && wr_idx == ADDR_CTRL) begin
         ctrl <= link_ctrl_t'(S_AXI_WDATA[1:0]);
      end
   end

   // Read address phase, no new address while data is pending
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_ARREADY <= 1'b0;
         rd_idx        <= '0;
      end else begin
         S_AXI_ARREADY <= !S_AXI_ARREADY && !S_AXI_RVALID && S_AXI_ARVALID;
         if (!S_AXI_ARREADY && !S_AXI_RVALID && S_AXI_ARVALID) begin
            rd_idx <= S_AXI_ARADDR[REG_ADDR_W-1:2];
         end
      end
   end

   always_comb begin
      case (rd_idx)
         ADDR_STAT:      rd_mux = {{(REG_DATA_W-2){1'b0}}, fifo_full, fifo_empty};
         ADDR_CTRL:      rd_mux = {{(REG_DATA_W-2){1'b0}}, ctrl};
         ADDR_CNT_IN_L:  rd_mux = cnt_in[31:0];
         ADDR_CNT_IN_H:  rd_mux = cnt_in[63:32];
         ADDR_CNT_OUT_H: rd_mux = cnt_out[63:32];
         ADDR_CNT_OUT_L: rd_mux = cnt_out[31:0];
         default:        rd_mux = '0;
      endcase
   end

   // Data follows the ARREADY pulse and holds until taken
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_RVALID <= 1'b0;
         S_AXI_RDATA  <= '0;
      end else if (S_AXI_ARREADY) begin
         S_AXI_RVALID <= 1'b1;
         S_AXI_RDATA  <= rd_mux;
      end else if (S_AXI_RREADY) begin
         S_AXI_RVALID <= 1'b0;
      end
   end

   // Frame ends seen on each link direction
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         cnt_in  <= '0;
         cnt_out <= '0;
      end else begin
         if (rx_beat.valid && rx_beat.last) cnt_in <= cnt_in + 1'b1;   // Link rx never stalls
         if (tx_beat.valid && tx_beat.last && tx_ready) cnt_out <= cnt_out + 1'b1;
      end
   end

endmodule

// ==== verilog/link_user_top.sv ====
module link_user_top
   import stream_pkg::*;
   import regs_pkg::*;
#(
   parameter int LOOP_DEPTH = 16
) (
   input  logic                  usr_clk,
   input  logic                  S_AXI_ARESETN,
   input  stream_beat_t          s_axis_tx,
   output logic                  s_axis_tx_ready,
   output stream_beat_t          m_axis_rx,
   output stream_beat_t          link_tx,
   input  logic                  link_tx_ready,
   input  stream_beat_t          link_rx,
   input  logic [REG_ADDR_W-1:0] S_AXI_AWADDR,
   input  logic                  S_AXI_AWVALID,
   output logic                  S_AXI_AWREADY,
   input  logic [REG_DATA_W-1:0] S_AXI_WDATA,
   input  logic                  S_AXI_WVALID,
   output logic                  S_AXI_WREADY,
   output logic                  S_AXI_BVALID,
   input  logic                  S_AXI_BREADY,
   input  logic [REG_ADDR_W-1:0] S_AXI_ARADDR,
   input  logic                  S_AXI_ARVALID,
   output logic                  S_AXI_ARREADY,
   output logic [REG_DATA_W-1:0] S_AXI_RDATA,
   output logic                  S_AXI_RVALID,
   input  logic                  S_AXI_RREADY
);

   link_ctrl_t   ctrl;
   stream_beat_t user_beat;   // User stream, blocked in loopback
   logic         app_in_ready;
   stream_beat_t app_beat;
   stream_beat_t loop_beat;
   logic         fifo_full;
   logic         fifo_empty;

   // User side is shut off while the link loops back
   always_comb begin
      user_beat       = s_axis_tx;
      user_beat.valid = s_axis_tx.valid && !ctrl.loopback;
   end
   assign s_axis_tx_ready = app_in_ready && !ctrl.loopback;

   assign link_tx = ctrl.loopback ? loop_beat : app_beat;

   seq_append u_append (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .in_beat       (user_beat),
      .in_ready      (app_in_ready),
      .out_beat      (app_beat),
      .out_ready     (link_tx_ready && !ctrl.loopback)
   );

   seq_strip u_strip (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .strip_en      (ctrl.strip_en),
      .in_beat       (link_rx),
      .out_beat      (m_axis_rx)
   );

   loop_fifo #(
      .LOOP_DEPTH (LOOP_DEPTH)
   ) u_loop (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .wr_en         (ctrl.loopback),
      .wr_beat       (link_rx),
      .rd_beat       (loop_beat),
      .rd_ready      (link_tx_ready && ctrl.loopback),
      .full          (fifo_full),
      .empty         (fifo_empty)
   );

   link_regs u_regs (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .S_AXI_AWADDR  (S_AXI_AWADDR),
      .S_AXI_AWVALID (S_AXI_AWVALID),
      .S_AXI_AWREADY (S_AXI_AWREADY),
      .S_AXI_WDATA   (S_AXI_WDATA),
      .S_AXI_WVALID  (S_AXI_WVALID),
      .S_AXI_WREADY  (S_AXI_WREADY),
      .S_AXI_BVALID  (S_AXI_BVALID),
      .S_AXI_BREADY  (S_AXI_BREADY),
      .S_AXI_ARADDR  (S_AXI_ARADDR),
      .S_AXI_ARVALID (S_AXI_ARVALID),
      .S_AXI_ARREADY (S_AXI_ARREADY),
      .S_AXI_RDATA   (S_AXI_RDATA),
      .S_AXI_RVALID  (S_AXI_RVALID),
      .S_AXI_RREADY  (S_AXI_RREADY),
      .ctrl          (ctrl),
      .rx_beat       (link_rx),
      .tx_beat       (link_tx),
      .tx_ready      (link_tx_ready),
      .fifo_full     (fifo_full),
      .fifo_empty    (fifo_empty)
   );

endmodule

// ==== verilog/loop_fifo.sv ====
module loop_fifo
   import stream_pkg::*;
#(
   parameter int LOOP_DEPTH = 16
) (
   input  logic         usr_clk,
   input  logic         S_AXI_ARESETN,
   input  logic         wr_en,
   input  stream_beat_t wr_beat,
   output stream_beat_t rd_beat,
   input  logic         rd_ready,
   output logic         full,
   output logic         empty
);

   localparam int AW = $clog2(LOOP_DEPTH);

   stream_beat_t mem [LOOP_DEPTH];
   logic [AW:0]  wr_ptr;   // Extra bit tells full from empty
   logic [AW:0]  rd_ptr;
   logic         do_wr;
   logic         do_rd;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

   assign do_wr = wr_en && wr_beat.valid && !full;   // Beats on a full FIFO are lost
   assign do_rd = rd_ready && !empty;

   // Head of the queue shows straight away
   assign rd_beat.valid = !empty;
   assign rd_beat.last  = mem[rd_ptr[AW-1:0]].last;
   assign rd_beat.data  = mem[rd_ptr[AW-1:0]].data;

   always_ff @(posedge usr_clk) begin
      if (do_wr) begin
         mem[wr_ptr[AW-1:0]] <= wr_beat;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

// ==== verilog/regs_pkg.sv ====
package regs_pkg;

   parameter int REG_ADDR_W = 6;
   parameter int REG_DATA_W = 32;

   // Word indices, address bits 5:2
   parameter logic [3:0] ADDR_STAT      = 4'd0;
   parameter logic [3:0] ADDR_CTRL      = 4'd1;
   parameter logic [3:0] ADDR_CNT_IN_L  = 4'd2;
   parameter logic [3:0] ADDR_CNT_IN_H  = 4'd3;
   parameter logic [3:0] ADDR_CNT_OUT_H = 4'd6;   // High word sits below low word here
   parameter logic [3:0] ADDR_CNT_OUT_L = 4'd7;

   // Control register, strip_en is bit 1 and loopback bit 0
   typedef struct packed {
      logic strip_en;
      logic loopback;
   } link_ctrl_t;

   // Stripping on, loopback off
   parameter link_ctrl_t CTRL_RESET = '{strip_en: 1'b1, loopback: 1'b0};

endpackage

// ==== verilog/seq_append.sv ====
module seq_append
   import stream_pkg::*;
(
   input  logic         usr_clk,
   input  logic         S_AXI_ARESETN,
   input  stream_beat_t in_beat,
   output logic         in_ready,
   output stream_beat_t out_beat,
   input  logic         out_ready
);

   stream_beat_t      out_reg;
   logic              seq_pend;   // Sequence word still to be sent
   logic [DATA_W-1:0] seq_cnt;
   logic              out_free;

   // Output register can take a new beat this cycle
   assign out_free = !out_reg.valid || out_ready;
   assign in_ready = out_free && !seq_pend;
   assign out_beat = out_reg;

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         out_reg  <= BEAT_IDLE;
         seq_pend <= 1'b0;
      end else if (out_free) begin
         if (seq_pend) begin
            // Trailing word closes the frame
            out_reg.valid <= 1'b1;
            out_reg.last  <= 1'b1;
            out_reg.data  <= seq_cnt;
            seq_pend      <= 1'b0;
         end else if (in_beat.valid) begin
            out_reg.valid <= 1'b1;
            out_reg.last  <= 1'b0;            // Frame end moves to the sequence word
            out_reg.data  <= in_beat.data;
            seq_pend      <= in_beat.last;
         end else begin
            out_reg.valid <= 1'b0;
         end
      end
   end

   // Count advances once the sequence word has left
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         seq_cnt <= '0;
      end else if (out_reg.valid && out_reg.last && out_ready) begin
         seq_cnt <= seq_cnt + 1'b1;
      end
   end

endmodule

// ==== verilog/seq_strip.sv ====
module seq_strip
   import stream_pkg::*;
(
   input  logic         usr_clk,
   input  logic         S_AXI_ARESETN,
   input  logic         strip_en,
   input  stream_beat_t in_beat,
   output stream_beat_t out_beat
);

   logic [DATA_W-1:0] hold_data;   // Beat waiting to see what follows
   logic              hold_vld;
   stream_beat_t      out_reg;

   assign out_beat = out_reg;

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         out_reg  <= BEAT_IDLE;
         hold_vld <= 1'b0;
      end else if (!strip_en) begin
         // Plain one-cycle stage
         out_reg  <= in_beat;
         hold_vld <= 1'b0;
      end else if (in_beat.valid) begin
         if (!in_beat.last) begin
            // Held beat is not the frame end, pass it on
            out_reg.valid <= hold_vld;
            out_reg.last  <= 1'b0;
            out_reg.data  <= hold_data;
            hold_vld      <= 1'b1;
         end else begin
            // Trailing word dropped, held beat becomes the frame end
            out_reg.valid <= hold_vld;
            out_reg.last  <= 1'b1;
            out_reg.data  <= hold_data;
            hold_vld      <= 1'b0;
         end
      end else begin
         out_reg.valid <= 1'b0;
      end
   end

   // Payload capture
   always_ff @(posedge usr_clk) begin
      if (strip_en && in_beat.valid && !in_beat.last) begin
         hold_data <= in_beat.data;
      end
   end

endmodule

// ==== verilog/stream_pkg.sv ====
package stream_pkg;

   // Link and user streams are one 32-bit word per beat
   parameter int DATA_W = 32;

   // One stream beat, valid on top
   typedef struct packed {
      logic              valid;
      logic              last;   // Frame end
      logic [DATA_W-1:0] data;
   } stream_beat_t;

   // Empty beat, handy for reset values
   parameter stream_beat_t BEAT_IDLE = '{valid: 1'b0, last: 1'b0, data: '0};

endpackage
